// ==== hw/tnoc_link_pkg.sv ====
package tnoc_link_pkg;
  localparam int FLIT_PAYLOAD_WIDTH = 32;
  localparam int FLIT_TYPE_WIDTH    = 2;
  localparam int FLIT_WIDTH         = FLIT_TYPE_WIDTH + FLIT_PAYLOAD_WIDTH;

  // Flit type lives in the top bits of each flit.
  typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
    TNOC_HEAD_FLIT      = 2'b00,
    TNOC_BODY_FLIT      = 2'b01,
    TNOC_TAIL_FLIT      = 2'b10,
    TNOC_HEAD_TAIL_FLIT = 2'b11
  } tnoc_flit_type;

  typedef enum logic {
    ARB_IDLE   = 1'b0,
    ARB_LOCKED = 1'b1
  } tnoc_arb_state;

  // Channel index width, never below one bit.
  function automatic int tnoc_vc_width(int channels);
    return (channels > 1) ? $clog2(channels) : 1;
  endfunction

  // Tail and head-tail flits close a packet.
  function automatic logic is_tail_flit(logic [FLIT_WIDTH-1:0] flit);
    tnoc_flit_type flit_type;
    flit_type = tnoc_flit_type'(flit[FLIT_WIDTH-1-:FLIT_TYPE_WIDTH]);
    return (flit_type == TNOC_TAIL_FLIT) || (flit_type == TNOC_HEAD_TAIL_FLIT);
  endfunction
endpackage

// ==== hw/tnoc_fifo.sv ====
`timescale 1ns/100ps

module tnoc_fifo
  import tnoc_link_pkg::*;
#(
  parameter int WIDTH     = FLIT_WIDTH,
  parameter int DEPTH     = 8,
  parameter int THRESHOLD = DEPTH
)(
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_clear,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic             o_empty,
  output logic             o_almost_full,
  output logic             o_full,
  output logic [WIDTH-1:0] o_data
);
  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]       mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   push;
  logic                   pop;

  // Wraps for depths that are not a power of two.
  function automatic logic [PTR_WIDTH-1:0] next_ptr(logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = i_push && !o_full;
  assign pop  = i_pop && !o_empty;

  assign o_empty       = (count == '0);
  assign o_almost_full = (count >= COUNT_WIDTH'(THRESHOLD));
  assign o_full        = (count == COUNT_WIDTH'(DEPTH));
  assign o_data        = mem[rd_ptr];  // Head entry.

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) count <= count + 1'b1;
      else if (!push && pop) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= i_data;
  end

  ast_no_push_when_full: assert property (
    @(posedge clk) disable iff (!i_rst_n) !(i_push && o_full)
  ) else $error("tnoc_fifo: push while full");

  ast_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!i_rst_n) !(i_pop && o_empty)
  ) else $error("tnoc_fifo: pop while empty");
endmodule

// ==== hw/tnoc_flit_if_fifo.sv ====
`timescale 1ns/100ps

module tnoc_flit_if_fifo
  import tnoc_link_pkg::*;
#(
  parameter int CHANNELS  = 2,
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH
)(
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear,
  input  logic [CHANNELS-1:0]            i_flit_valid,
  input  logic [FLIT_WIDTH-1:0]          i_flit,
  output logic [CHANNELS-1:0]            o_flit_ready,
  output logic [CHANNELS-1:0]            o_vc_available,
  output logic [CHANNELS-1:0]            o_empty,
  input  logic [CHANNELS-1:0]            i_pop,
  output logic [CHANNELS*FLIT_WIDTH-1:0] o_data
);
  logic [CHANNELS-1:0] almost_full;
  logic [CHANNELS-1:0] full;

  for (genvar i = 0; i < CHANNELS; ++i) begin : g_fifo
    logic push;

    // Write only what the channel can take.
    assign push              = i_flit_valid[i] && !full[i];
    assign o_flit_ready[i]   = ~full[i];
    assign o_vc_available[i] = ~almost_full[i];  // Credit level.

    tnoc_fifo #(
      .WIDTH     (FLIT_WIDTH ),
      .DEPTH     (DEPTH      ),
      .THRESHOLD (THRESHOLD  )
    ) u_fifo (
      .clk           (clk                                     ),
      .i_rst_n       (i_rst_n                                 ),
      .i_clear       (i_clear                                 ),
      .i_push        (push                                    ),
      .i_data        (i_flit                                  ),
      .i_pop         (i_pop[i]                                ),
      .o_empty       (o_empty[i]                              ),
      .o_almost_full (almost_full[i]                          ),
      .o_full        (full[i]                                 ),
      .o_data        (o_data[i*FLIT_WIDTH+:FLIT_WIDTH]        )
    );
  end

  // One flit bus, so one channel per cycle.
  ast_valid_onehot: assert property (
    @(posedge clk) disable iff (!i_rst_n) $onehot0(i_flit_valid)
  ) else $error("tnoc_flit_if_fifo: more than one channel valid");
endmodule

// ==== hw/tnoc_vc_arbiter.sv ====
`timescale 1ns/100ps

module tnoc_vc_arbiter
  import tnoc_link_pkg::*;
#(
  parameter  int CHANNELS = 2,
  localparam int VC_WIDTH = tnoc_vc_width(CHANNELS)
)(
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear,
  input  logic [CHANNELS-1:0]            i_empty,
  input  logic [CHANNELS*FLIT_WIDTH-1:0] i_data,
  input  logic                           i_slot_ready,
  output logic [CHANNELS-1:0]            o_pop,
  output logic                           o_valid,
  output logic [FLIT_WIDTH-1:0]          o_flit,
  output logic [VC_WIDTH-1:0]            o_vc
);
  tnoc_arb_state       state;
  logic [VC_WIDTH-1:0] lock_vc;
  logic [VC_WIDTH-1:0] last_vc;
  logic [VC_WIDTH-1:0] rr_vc;
  logic                transfer;

  // First non-empty channel after the last grant.
  always_comb begin
    int idx;
    rr_vc = last_vc;
    for (int i = CHANNELS; i >= 1; --i) begin
      idx = (int'(last_vc) + i) % CHANNELS;
      if (!i_empty[idx]) rr_vc = VC_WIDTH'(idx);
    end
  end

  assign o_vc     = (state == ARB_LOCKED) ? lock_vc : rr_vc;
  assign o_valid  = !i_empty[o_vc];
  assign o_flit   = i_data[o_vc*FLIT_WIDTH+:FLIT_WIDTH];
  assign transfer = o_valid && i_slot_ready;

  always_comb begin
    o_pop = '0;
    if (transfer) o_pop[o_vc] = 1'b1;  // Same cycle as the slot load.
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= ARB_IDLE;
      lock_vc <= '0;
      last_vc <= VC_WIDTH'(CHANNELS - 1);
    end else if (i_clear) begin
      state   <= ARB_IDLE;
      lock_vc <= '0;
      last_vc <= VC_WIDTH'(CHANNELS - 1);
    end else if (transfer) begin
      // Hold the channel until its tail goes out.
      state   <= is_tail_flit(o_flit) ? ARB_IDLE : ARB_LOCKED;
      lock_vc <= o_vc;
      last_vc <= o_vc;
    end
  end

  ast_pop_onehot: assert property (
    @(posedge clk) disable iff (!i_rst_n) $onehot0(o_pop)
  ) else $error("tnoc_vc_arbiter: pop is not one-hot");
endmodule

// ==== hw/tnoc_link_output_stage.sv ====
`timescale 1ns/100ps

module tnoc_link_output_stage
  import tnoc_link_pkg::*;
#(
  parameter  int CHANNELS = 2,
  localparam int VC_WIDTH = tnoc_vc_width(CHANNELS)
)(
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_clear,
  input  logic                  i_valid,
  input  logic [FLIT_WIDTH-1:0] i_flit,
  input  logic [VC_WIDTH-1:0]   i_vc,
  input  logic                  i_ready,
  output logic                  o_slot_ready,
  output logic                  o_flit_valid,
  output logic [FLIT_WIDTH-1:0] o_flit,
  output logic [VC_WIDTH-1:0]   o_flit_vc
);
  logic slot_valid;
  logic load;

  // Free, or draining this cycle.
  assign o_slot_ready = !slot_valid || i_ready;
  assign load         = i_valid && o_slot_ready;
  assign o_flit_valid = slot_valid;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      slot_valid <= 1'b0;
    end else if (i_clear) begin
      slot_valid <= 1'b0;
    end else if (load) begin
      slot_valid <= 1'b1;
    end else if (i_ready) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load && !i_clear) begin
      o_flit    <= i_flit;
      o_flit_vc <= i_vc;
    end
  end

  // Link sees a steady flit while it stalls.
  ast_hold_stable: assert property (
    @(posedge clk) disable iff (!i_rst_n || i_clear)
    (o_flit_valid && !i_ready) |=>
      (o_flit_valid && $stable(o_flit) && $stable(o_flit_vc))
  ) else $error("tnoc_link_output_stage: output changed under back-pressure");
endmodule

// ==== hw/tnoc_vc_link.sv ====
`timescale 1ns/100ps

module tnoc_vc_link
  import tnoc_link_pkg::*;
#(
  parameter  int CHANNELS  = 2,
  parameter  int DEPTH     = 4,
  parameter  int THRESHOLD = 3,
  localparam int VC_WIDTH  = tnoc_vc_width(CHANNELS)
)(
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_clear,
  input  logic [CHANNELS-1:0]   i_flit_valid,
  input  logic [FLIT_WIDTH-1:0] i_flit,
  output logic [CHANNELS-1:0]   o_flit_ready,
  output logic [CHANNELS-1:0]   o_vc_available,
  output logic                  o_flit_valid,
  output logic [FLIT_WIDTH-1:0] o_flit,
  output logic [VC_WIDTH-1:0]   o_flit_vc,
  input  logic                  i_flit_ready
);
  logic [CHANNELS-1:0]            fifo_empty;
  logic [CHANNELS*FLIT_WIDTH-1:0] fifo_data;
  logic [CHANNELS-1:0]            fifo_pop;
  logic                           arb_valid;
  logic [FLIT_WIDTH-1:0]          arb_flit;
  logic [VC_WIDTH-1:0]            arb_vc;
  logic                           slot_ready;

  tnoc_flit_if_fifo #(
    .CHANNELS  (CHANNELS  ),
    .DEPTH     (DEPTH     ),
    .THRESHOLD (THRESHOLD )
  ) u_flit_if_fifo (
    .clk            (clk            ),
    .i_rst_n        (i_rst_n        ),
    .i_clear        (i_clear        ),
    .i_flit_valid   (i_flit_valid   ),
    .i_flit         (i_flit         ),
    .o_flit_ready   (o_flit_ready   ),
    .o_vc_available (o_vc_available ),
    .o_empty        (fifo_empty     ),
    .i_pop          (fifo_pop       ),
    .o_data         (fifo_data      )
  );

  tnoc_vc_arbiter #(
    .CHANNELS (CHANNELS )
  ) u_vc_arbiter (
    .clk          (clk        ),
    .i_rst_n      (i_rst_n    ),
    .i_clear      (i_clear    ),
    .i_empty      (fifo_empty ),
    .i_data       (fifo_data  ),
    .i_slot_ready (slot_ready ),
    .o_pop        (fifo_pop   ),
    .o_valid      (arb_valid  ),
    .o_flit       (arb_flit   ),
    .o_vc         (arb_vc     )
  );

  tnoc_link_output_stage #(
    .CHANNELS (CHANNELS )
  ) u_link_output_stage (
    .clk          (clk          ),
    .i_rst_n      (i_rst_n      ),
    .i_clear      (i_clear      ),
    .i_valid      (arb_valid    ),
    .i_flit       (arb_flit     ),
    .i_vc         (arb_vc       ),
    .i_ready      (i_flit_ready ),
    .o_slot_ready (slot_ready   ),
    .o_flit_valid (o_flit_valid ),
    .o_flit       (o_flit       ),
    .o_flit_vc    (o_flit_vc    )
  );
endmodule

// ==== dv/tnoc_vc_link_tb.sv ====
`timescale 1ns/100ps

module tnoc_vc_link_tb
  import tnoc_link_pkg::*;
();
  localparam int CHANNELS  = 2;
  localparam int DEPTH     = 4;
  localparam int THRESHOLD = 3;
  localparam int VC_WIDTH  = tnoc_vc_width(CHANNELS);

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_clear;
  logic [CHANNELS-1:0]   i_flit_valid;
  logic [FLIT_WIDTH-1:0] i_flit;
  logic [CHANNELS-1:0]   o_flit_ready;
  logic [CHANNELS-1:0]   o_vc_available;
  logic                  o_flit_valid;
  logic [FLIT_WIDTH-1:0] o_flit;
  logic [VC_WIDTH-1:0]   o_flit_vc;
  logic                  i_flit_ready;

  logic [FLIT_WIDTH-1:0] exp_q [CHANNELS][$];  // Per-channel scoreboard.
  tnoc_arb_state         exp_arb;
  int                    lock_vc;
  logic                  rr_check;
  int                    rr_last_vc;
  logic [31:0]           rng_state;
  string                 cur_test;
  int                    errors;
  int                    test_errors;
  int                    tests_passed;
  int                    tests_failed;
  int                    cycles;
  int                    cycle_limit;

  tnoc_vc_link #(
    .CHANNELS  (CHANNELS ),
    .DEPTH     (DEPTH    ),
    .THRESHOLD (THRESHOLD)
  ) u_tnoc_vc_link (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [FLIT_WIDTH-1:0] make_flit(int idx, int len,
                                                      logic [FLIT_PAYLOAD_WIDTH-1:0] payload);
    tnoc_flit_type ftype;
    if (len == 1) ftype = TNOC_HEAD_TAIL_FLIT;
    else if (idx == 0) ftype = TNOC_HEAD_FLIT;
    else if (idx == len - 1) ftype = TNOC_TAIL_FLIT;
    else ftype = TNOC_BODY_FLIT;
    return {ftype, payload};
  endfunction

  function automatic logic [CHANNELS-1:0] channel_bit(int ch);
    logic [CHANNELS-1:0] v;
    v     = '0;
    v[ch] = 1'b1;
    return v;
  endfunction

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int c = 0; c < CHANNELS; c++) n += exp_q[c].size();
    return n;
  endfunction

  task automatic report_value(string what, logic [63:0] expected, logic [63:0] actual);
    $display("[ERROR] %s: %s expected %0h, actual %0h", cur_test, what, expected, actual);
    errors++;
  endtask

  task automatic report_fault(string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic begin_test(string name);
    cur_test    = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      tests_passed++;
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, errors - test_errors);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Every flit and stall cycle widens the timeout.
  task automatic apply(logic [CHANNELS-1:0] valid, logic [FLIT_WIDTH-1:0] data, logic rdy);
    i_flit_valid = valid;
    i_flit       = data;
    i_flit_ready = rdy;
    if (valid != '0) cycle_limit += 4;
    if (!rdy) cycle_limit += 4;
  endtask

  task automatic wait_drain();
    apply('0, '0, 1'b1);
    do begin
      next_cycle();
    end while (pending_flits() != 0 || o_flit_valid);
  endtask

  task automatic check_idle();
    assert (!o_flit_valid) else report_value("o_flit_valid", 64'(0), 64'(o_flit_valid));
    assert (o_flit_ready == '1)
      else report_value("o_flit_ready", 64'({CHANNELS{1'b1}}), 64'(o_flit_ready));
    assert (o_vc_available == '1)
      else report_value("o_vc_available", 64'({CHANNELS{1'b1}}), 64'(o_vc_available));
  endtask

  // Scoreboard, credit model and packet lock.
  always @(posedge clk) begin
    int                    occ;
    int                    vc;
    logic [FLIT_WIDTH-1:0] expected;
    tnoc_flit_type         ftype;
    if (!i_rst_n || i_clear) begin
      for (int c = 0; c < CHANNELS; c++) exp_q[c].delete();
      exp_arb = ARB_IDLE;
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        // The slot's flit has already left its FIFO.
        occ = exp_q[c].size() - ((o_flit_valid && int'(o_flit_vc) == c) ? 1 : 0);
        assert (o_vc_available[c] == (occ < THRESHOLD)) else report_value(
          $sformatf("o_vc_available[%0d]", c), 64'(occ < THRESHOLD), 64'(o_vc_available[c]));
        assert (o_flit_ready[c] == (occ < DEPTH)) else report_value(
          $sformatf("o_flit_ready[%0d]", c), 64'(occ < DEPTH), 64'(o_flit_ready[c]));
        if (i_flit_valid[c] && o_flit_ready[c]) exp_q[c].push_back(i_flit);
      end
      if (o_flit_valid && i_flit_ready) begin
        vc    = int'(o_flit_vc);
        ftype = tnoc_flit_type'(o_flit[FLIT_WIDTH-1-:FLIT_TYPE_WIDTH]);
        if (exp_q[vc].size() == 0) begin
          report_fault($sformatf("flit %0h left on channel %0d with none pending", o_flit, vc));
        end else begin
          expected = exp_q[vc].pop_front();
          assert (o_flit == expected) else report_value(
            $sformatf("flit on channel %0d", vc), 64'(expected), 64'(o_flit));
        end
        if (exp_arb == ARB_LOCKED) begin
          assert (vc == lock_vc)
            else report_value("o_flit_vc inside a packet", 64'(lock_vc), 64'(vc));
          assert (ftype == TNOC_BODY_FLIT || ftype == TNOC_TAIL_FLIT)
            else report_fault("head flit appeared while a packet was still open");
        end else begin
          assert (ftype == TNOC_HEAD_FLIT || ftype == TNOC_HEAD_TAIL_FLIT)
            else report_fault("body or tail flit appeared outside a packet");
        end
        if (ftype == TNOC_HEAD_FLIT) begin
          exp_arb = ARB_LOCKED;
          lock_vc = vc;
        end else if (ftype != TNOC_BODY_FLIT) begin
          exp_arb = ARB_IDLE;  // Tail closes it.
        end
        if (rr_check && rr_last_vc >= 0) begin
          assert (vc != rr_last_vc)
            else report_value("o_flit_vc under round robin", 64'(1 - rr_last_vc), 64'(vc));
        end
        rr_last_vc = vc;
      end
    end
  end

  ast_output_hold: assert property (
    @(posedge clk) disable iff (!i_rst_n || i_clear)
    (o_flit_valid && !i_flit_ready) |=>
      (o_flit_valid && $stable(o_flit) && $stable(o_flit_vc))
  ) else report_fault("output flit changed while the link was stalled");

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the link stopped delivering flits.", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int   ch;
    int   len;
    int   idx;
    logic rdy;
    rng_state    = 32'd18;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;
    cycle_limit  = 200;
    rr_check     = 1'b0;
    rr_last_vc   = -1;
    lock_vc      = 0;
    i_rst_n      = 1'b0;
    i_clear      = 1'b0;
    i_flit_valid = '0;
    i_flit       = '0;
    i_flit_ready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    i_rst_n = 1'b1;

    begin_test("reset_clear");
    check_idle();
    for (int i = 0; i < 2 * DEPTH + 1; i++) begin
      next_cycle();
      apply(channel_bit(i % CHANNELS), make_flit(0, 1, next_random()), 1'b0);
    end
    next_cycle();
    apply('0, '0, 1'b0);
    i_clear = 1'b1;
    next_cycle();
    i_clear = 1'b0;
    check_idle();
    wait_drain();
    repeat (4) next_cycle();  // Stale flits would show up here.
    end_test();

    begin_test("latency");
    next_cycle();
    apply(channel_bit(0), make_flit(0, 1, next_random()), 1'b1);
    next_cycle();
    apply('0, '0, 1'b1);
    assert (!o_flit_valid) else report_value("o_flit_valid at N+1", 64'(0), 64'(o_flit_valid));
    next_cycle();
    assert (o_flit_valid) else report_value("o_flit_valid at N+2", 64'(1), 64'(o_flit_valid));
    wait_drain();
    end_test();

    begin_test("backpressure");
    for (int i = 0; i < 2 * DEPTH; i++) begin
      next_cycle();
      apply(channel_bit(0), make_flit(0, 1, next_random()), 1'b0);
    end
    next_cycle();
    apply('0, '0, 1'b0);
    assert (!o_flit_ready[0]) else report_value("o_flit_ready[0]", 64'(0), 64'(o_flit_ready[0]));
    assert (!o_vc_available[0])
      else report_value("o_vc_available[0]", 64'(0), 64'(o_vc_available[0]));
    repeat (3) begin
      next_cycle();
      apply('0, '0, 1'b0);
    end
    wait_drain();
    end_test();

    // Slot plus two full FIFOs before the link opens.
    begin_test("round_robin");
    rr_last_vc = -1;
    for (int i = 0; i < 2 * DEPTH + 1; i++) begin
      next_cycle();
      apply(channel_bit(i % CHANNELS), make_flit(0, 1, next_random()), 1'b0);
    end
    next_cycle();
    apply('0, '0, 1'b0);
    rr_check = 1'b1;
    wait_drain();
    rr_check = 1'b0;
    end_test();

    begin_test("random_traffic");
    for (int p = 0; p < 40; p++) begin
      ch  = int'(next_random() % CHANNELS);
      len = int'(next_random() % 4) + 1;
      idx = 0;
      while (idx < len) begin
        next_cycle();
        rdy = (next_random() % 4) != 0;
        if (o_flit_ready[ch]) begin
          apply(channel_bit(ch), make_flit(idx, len, next_random()), rdy);
          idx++;
        end else begin
          apply('0, '0, rdy);
        end
      end
    end
    wait_drain();
    end_test();

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end
endmodule

// ==== tnoc_vc_link.f ====
hw/tnoc_link_pkg.sv
hw/tnoc_fifo.sv
hw/tnoc_flit_if_fifo.sv
hw/tnoc_vc_arbiter.sv
hw/tnoc_link_output_stage.sv
hw/tnoc_vc_link.sv
dv/tnoc_vc_link_tb.sv

// ==== Makefile ====
TOP := tnoc_vc_link_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tnoc_vc_link.f --top-module $(TOP)

obj_dir/V$(TOP): tnoc_vc_link.f $(wildcard hw/*.sv dv/*.sv)
	verilator --binary --timing --assert -j 0 -f tnoc_vc_link.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir
